//--- hdl/sfpp_csr_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SFP+ control and status register map
// Wishbone offsets, field widths and bit positions
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package sfpp_csr_pkg;

    // Wishbone bus widths
    localparam int WB_DATA_W = 32;
    localparam int WB_ADDR_W = 8;
    // Byte lane bits below this index are not decoded
    localparam int WB_ADDR_LSB = 2;

    // Register offsets
    localparam logic [WB_ADDR_W-1:0] REG_ID          = 8'h00;
    localparam logic [WB_ADDR_W-1:0] REG_GT_STATUS   = 8'h04;
    localparam logic [WB_ADDR_W-1:0] REG_GT_CONTROL  = 8'h08;
    localparam logic [WB_ADDR_W-1:0] REG_PHY_STATUS  = 8'h0C;
    localparam logic [WB_ADDR_W-1:0] REG_PHY_CONTROL = 8'h10;

    // Field widths
    localparam int GT_STATUS_W   = 13;
    localparam int GT_CONTROL_W  = 6;
    // Block lock in bit 0, high BER in bit 1
    localparam int PHY_STATUS_W  = 2;
    localparam int PHY_CONTROL_W = 1;

    // Transceiver status bits that this core fills in or consumes
    localparam int GT_STATUS_LOCK_RST = 1;
    localparam int GT_STATUS_TX_DONE  = 4;
    localparam int GT_STATUS_RX_DONE  = 7;
    localparam int GT_STATUS_PLL_LOCK = 10;

    // Control bit positions
    localparam int GT_CTRL_HOLD_RESET = 0;
    localparam int PHY_CTRL_LOOPBACK  = 0;

    // Presence word at the identity offset
    localparam logic [WB_DATA_W-1:0] SFPP_ID_VALUE = 32'd1;

endpackage

`default_nettype wire

//--- hdl/xgmii_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// XGMII definitions
// Lane widths and the idle character
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package xgmii_pkg;

    // Eight byte lanes per 64-bit transfer
    localparam int XGMII_LANES  = 8;
    localparam int XGMII_LANE_W = 8;

    // Data and control bus widths
    localparam int XGMII_DATA_W = XGMII_LANES * XGMII_LANE_W;
    // One control bit per lane
    localparam int XGMII_CTRL_W = XGMII_LANES;

    // Idle control character
    localparam logic [XGMII_LANE_W-1:0] XGMII_IDLE_CHAR = 8'h07;

    // Idle on every lane, all lanes flagged as control
    localparam logic [XGMII_DATA_W-1:0] XGMII_IDLE_DATA = {XGMII_LANES{XGMII_IDLE_CHAR}};
    localparam logic [XGMII_CTRL_W-1:0] XGMII_IDLE_CTRL = '1;

endpackage

`default_nettype wire

//--- hdl/reset_sync.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reset synchronizer with immediate assert
// and release after SYNC_STAGES clean cycles
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module reset_sync #(
    parameter int SYNC_STAGES = 4
) (
    input  wire logic clk_i,
    input  wire logic rst_i,
    output logic      rst_o
);

    // Release shift register, last stage drives the output
    logic [SYNC_STAGES-1:0] rst_sreg;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            // Any request fills the chain so the output rises on this edge
            rst_sreg <= '1;
        end else begin
            // Shift zeros towards the output
            rst_sreg <= {rst_sreg[SYNC_STAGES-2:0], 1'b0};
        end
    end

    assign rst_o = rst_sreg[SYNC_STAGES-1];

endmodule

`default_nettype wire

//--- hdl/level_sync.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multi-stage synchronizer for quasi-static levels
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module level_sync #(
    parameter int  SYNC_STAGES = 4,
    parameter type payload_t   = logic
) (
    // Destination clock
    input  wire logic     clk_i,
    // Source levels, may change at any time
    input  wire payload_t data_i,
    // Levels in the destination domain
    output payload_t      data_o
);

    // Synchronizer chain, stage 0 samples the source
    payload_t sync_q [SYNC_STAGES];

    // Only suitable for bits that stay put for many destination cycles,
    // a bundle may show a mix of old and new bits for one cycle
    always_ff @(posedge clk_i) begin
        sync_q[0] <= data_i;
        for (int i = 1; i < SYNC_STAGES; i++) begin
            sync_q[i] <= sync_q[i-1];
        end
    end

    // Output after SYNC_STAGES destination edges
    assign data_o = sync_q[SYNC_STAGES-1];

endmodule

`default_nettype wire

//--- hdl/xgmii_loopback.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// XGMII loopback selector towards the PHY
// Bridge or received words, idle while in reset
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module xgmii_loopback (
    // Transmit clock and transmit reset
    input  wire logic                                clk_i,
    input  wire logic                                reset_i,
    // Loopback select, already in the transmit domain
    input  wire logic                                loopback_i,
    // Words from the bridge
    input  wire logic [xgmii_pkg::XGMII_DATA_W-1:0]  tx_data_i,
    input  wire logic [xgmii_pkg::XGMII_CTRL_W-1:0]  tx_ctrl_i,
    // Words received from the PHY
    input  wire logic [xgmii_pkg::XGMII_DATA_W-1:0]  rx_data_i,
    input  wire logic [xgmii_pkg::XGMII_CTRL_W-1:0]  rx_ctrl_i,
    // Words to the PHY transmit side
    output logic      [xgmii_pkg::XGMII_DATA_W-1:0]  phy_data_o,
    output logic      [xgmii_pkg::XGMII_CTRL_W-1:0]  phy_ctrl_o
);

    import xgmii_pkg::*;

    // Receive words are taken straight into the transmit clock,
    // both clocks must run at the same frequency
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            // Keep the link fed with idle until the transmit path is up
            phy_data_o <= XGMII_IDLE_DATA;
            phy_ctrl_o <= XGMII_IDLE_CTRL;
        end else if (loopback_i) begin
            // Loop received traffic back out
            phy_data_o <= rx_data_i;
            phy_ctrl_o <= rx_ctrl_i;
        end else begin
            // Normal operation
            phy_data_o <= tx_data_i;
            phy_ctrl_o <= tx_ctrl_i;
        end
    end

endmodule

`default_nettype wire

//--- hdl/sfpp_csr.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SFP+ Wishbone register file
// Identity, status and control words for transceiver and PHY
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module sfpp_csr (
    input  wire logic                                   wb_clk_i,
    input  wire logic                                   reset_i,
    // Wishbone slave
    input  wire logic                                   wb_cyc_i,
    input  wire logic                                   wb_stb_i,
    input  wire logic                                   wb_we_i,
    input  wire logic [sfpp_csr_pkg::WB_ADDR_W-1:0]     wb_adr_i,
    input  wire logic [sfpp_csr_pkg::WB_DATA_W-1:0]     wb_dat_i,
    output logic      [sfpp_csr_pkg::WB_DATA_W-1:0]     wb_dat_o,
    output logic                                        wb_ack_o,
    // Status, already in the Wishbone clock
    input  wire logic [sfpp_csr_pkg::GT_STATUS_W-1:0]   gt_status_i,
    input  wire logic [sfpp_csr_pkg::PHY_STATUS_W-1:0]  phy_status_i,
    // Control registers
    output logic      [sfpp_csr_pkg::GT_CONTROL_W-1:0]  gt_control_o,
    output logic      [sfpp_csr_pkg::PHY_CONTROL_W-1:0] phy_control_o
);

    import sfpp_csr_pkg::*;

    // Word address width after dropping the byte lane bits
    localparam int WORD_ADR_W = WB_ADDR_W - WB_ADDR_LSB;

    // Word addresses of the registers
    localparam logic [WORD_ADR_W-1:0] ADR_ID = REG_ID[WB_ADDR_W-1:WB_ADDR_LSB];
    localparam logic [WORD_ADR_W-1:0] ADR_GT_STATUS = REG_GT_STATUS[WB_ADDR_W-1:WB_ADDR_LSB];
    localparam logic [WORD_ADR_W-1:0] ADR_GT_CONTROL = REG_GT_CONTROL[WB_ADDR_W-1:WB_ADDR_LSB];
    localparam logic [WORD_ADR_W-1:0] ADR_PHY_STATUS = REG_PHY_STATUS[WB_ADDR_W-1:WB_ADDR_LSB];
    localparam logic [WORD_ADR_W-1:0] ADR_PHY_CONTROL =
        REG_PHY_CONTROL[WB_ADDR_W-1:WB_ADDR_LSB];

    // Bus request in this cycle
    logic                  req;
    // Decoded word address
    logic [WORD_ADR_W-1:0] word_adr;
    // Word selected for a read
    logic [WB_DATA_W-1:0]  rd_word;

    assign req      = wb_cyc_i && wb_stb_i;
    assign word_adr = wb_adr_i[WB_ADDR_W-1:WB_ADDR_LSB];

    // Read multiplexer, fields are zero extended
    always_comb begin
        rd_word = '0;
        case (word_adr)
            ADR_ID: begin
                rd_word = SFPP_ID_VALUE;
            end
            ADR_GT_STATUS: begin
                rd_word[GT_STATUS_W-1:0] = gt_status_i;
            end
            ADR_GT_CONTROL: begin
                rd_word[GT_CONTROL_W-1:0] = gt_control_o;
            end
            ADR_PHY_STATUS: begin
                rd_word[PHY_STATUS_W-1:0] = phy_status_i;
            end
            ADR_PHY_CONTROL: begin
                rd_word[PHY_CONTROL_W-1:0] = phy_control_o;
            end
            default: begin
                // Undecoded offsets read as zero
                rd_word = '0;
            end
        endcase
    end

    // Control registers, upper write bits are dropped
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            gt_control_o  <= '0;
            phy_control_o <= '0;
        end else begin
            if (req && wb_we_i && (word_adr == ADR_GT_CONTROL)) begin
                gt_control_o <= wb_dat_i[GT_CONTROL_W-1:0];
            end
            if (req && wb_we_i && (word_adr == ADR_PHY_CONTROL)) begin
                phy_control_o <= wb_dat_i[PHY_CONTROL_W-1:0];
            end
        end
    end

    // One acknowledge per request cycle, no wait states
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            wb_ack_o <= 1'b0;
            wb_dat_o <= '0;
        end else begin
            wb_ack_o <= req;
            // Data bus only carries a word alongside a read acknowledge
            if (req && !wb_we_i) begin
                wb_dat_o <= rd_word;
            end else begin
                wb_dat_o <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/sfpp_link_ctrl.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SFP+ 10G link control and status core
// Resets, clock crossings, registers and XGMII loopback
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module sfpp_link_ctrl #(
    parameter int SYNC_STAGES = 4
) (
    // Clocks and resets
    input  wire logic                                   wb_clk_i,
    input  wire logic                                   reset_i,
    input  wire logic                                   freerun_clk_i,
    input  wire logic                                   freerun_rst_i,
    // Transmit and receive clocks must share one frequency
    input  wire logic                                   xgmii_tx_clk_i,
    input  wire logic                                   xgmii_rx_clk_i,
    // External PLL lock
    input  wire logic                                   pll_lock_i,
    // Wishbone slave
    input  wire logic                                   wb_cyc_i,
    input  wire logic                                   wb_stb_i,
    input  wire logic                                   wb_we_i,
    input  wire logic [sfpp_csr_pkg::WB_ADDR_W-1:0]     wb_adr_i,
    input  wire logic [sfpp_csr_pkg::WB_DATA_W-1:0]     wb_dat_i,
    output logic      [sfpp_csr_pkg::WB_DATA_W-1:0]     wb_dat_o,
    output logic                                        wb_ack_o,
    // Transceiver status, bits 1 and 10 are filled in here
    input  wire logic [sfpp_csr_pkg::GT_STATUS_W-1:0]   gt_status_i,
    // PHY block lock and high BER
    input  wire logic [sfpp_csr_pkg::PHY_STATUS_W-1:0]  phy_status_i,
    // Transceiver control
    output logic                                        gt_reset_all_o,
    output logic      [sfpp_csr_pkg::GT_CONTROL_W-1:0]  gt_control_o,
    // XGMII from the bridge and from the PHY
    input  wire logic [xgmii_pkg::XGMII_DATA_W-1:0]     xgmii_tx_data_i,
    input  wire logic [xgmii_pkg::XGMII_CTRL_W-1:0]     xgmii_tx_ctrl_i,
    input  wire logic [xgmii_pkg::XGMII_DATA_W-1:0]     xgmii_rx_data_i,
    input  wire logic [xgmii_pkg::XGMII_CTRL_W-1:0]     xgmii_rx_ctrl_i,
    // XGMII towards the PHY and the XGMII resets
    output logic      [xgmii_pkg::XGMII_DATA_W-1:0]     xgmii_phy_tx_data_o,
    output logic      [xgmii_pkg::XGMII_CTRL_W-1:0]     xgmii_phy_tx_ctrl_o,
    output logic                                        xgmii_tx_rst_o,
    output logic                                        xgmii_rx_rst_o
);

    import sfpp_csr_pkg::*;

    // PHY status sits above the transceiver status in the bundle
    typedef logic [GT_STATUS_W+PHY_STATUS_W-1:0] status_t;
    typedef logic [PHY_CONTROL_W-1:0]            phy_ctrl_t;

    // Register file outputs in the Wishbone clock
    logic [GT_CONTROL_W-1:0] csr_gt_control;
    phy_ctrl_t               csr_phy_control;
    // Hold-reset bit in the freerun clock
    logic                    hold_reset_fr;
    // Full transceiver status word
    logic [GT_STATUS_W-1:0]  gt_status_full;
    // Status bundle in the Wishbone clock
    status_t                 status_wb;
    // PHY control in the transmit clock
    phy_ctrl_t               phy_control_tx;

    // Hold-reset bit into the freerun domain
    level_sync #(
        .SYNC_STAGES (SYNC_STAGES),
        .payload_t   (logic)
    ) u_hold_reset_sync (
        .clk_i  (freerun_clk_i),
        .data_i (csr_gt_control[GT_CTRL_HOLD_RESET]),
        .data_o (hold_reset_fr)
    );

    // Transceiver reset, held while unlocked or on request
    reset_sync #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_gt_reset_sync (
        .clk_i (freerun_clk_i),
        .rst_i (freerun_rst_i | ~pll_lock_i | hold_reset_fr),
        .rst_o (gt_reset_all_o)
    );

    // Remaining control bits go straight to the transceiver
    always_comb begin
        gt_control_o = csr_gt_control;
        gt_control_o[GT_CTRL_HOLD_RESET] = 1'b0;
    end

    // Insert the locally known bits into the status word
    always_comb begin
        gt_status_full = gt_status_i;
        gt_status_full[GT_STATUS_LOCK_RST] = gt_reset_all_o;
        gt_status_full[GT_STATUS_PLL_LOCK] = pll_lock_i;
    end

    // Status from mixed domains into the Wishbone clock
    level_sync #(
        .SYNC_STAGES (SYNC_STAGES),
        .payload_t   (status_t)
    ) u_status_sync (
        .clk_i  (wb_clk_i),
        .data_i ({phy_status_i, gt_status_full}),
        .data_o (status_wb)
    );

    sfpp_csr u_csr (
        .wb_clk_i      (wb_clk_i),
        .reset_i       (reset_i),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr_i),
        .wb_dat_i      (wb_dat_i),
        .wb_dat_o      (wb_dat_o),
        .wb_ack_o      (wb_ack_o),
        .gt_status_i   (status_wb[GT_STATUS_W-1:0]),
        .phy_status_i  (status_wb[GT_STATUS_W +: PHY_STATUS_W]),
        .gt_control_o  (csr_gt_control),
        .phy_control_o (csr_phy_control)
    );

    // XGMII resets follow the transceiver reset-done flags
    reset_sync #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_tx_reset_sync (
        .clk_i (xgmii_tx_clk_i),
        .rst_i (~gt_status_i[GT_STATUS_TX_DONE]),
        .rst_o (xgmii_tx_rst_o)
    );

    reset_sync #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_rx_reset_sync (
        .clk_i (xgmii_rx_clk_i),
        .rst_i (~gt_status_i[GT_STATUS_RX_DONE]),
        .rst_o (xgmii_rx_rst_o)
    );

    // Loopback select into the transmit domain
    level_sync #(
        .SYNC_STAGES (SYNC_STAGES),
        .payload_t   (phy_ctrl_t)
    ) u_phy_ctrl_sync (
        .clk_i  (xgmii_tx_clk_i),
        .data_i (csr_phy_control),
        .data_o (phy_control_tx)
    );

    xgmii_loopback u_loopback (
        .clk_i      (xgmii_tx_clk_i),
        .reset_i    (xgmii_tx_rst_o),
        .loopback_i (phy_control_tx[PHY_CTRL_LOOPBACK]),
        .tx_data_i  (xgmii_tx_data_i),
        .tx_ctrl_i  (xgmii_tx_ctrl_i),
        .rx_data_i  (xgmii_rx_data_i),
        .rx_ctrl_i  (xgmii_rx_ctrl_i),
        .phy_data_o (xgmii_phy_tx_data_o),
        .phy_ctrl_o (xgmii_phy_tx_ctrl_o)
    );

endmodule

`default_nettype wire

//--- include/sfpp_tb_tests.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus helpers and directed tests for the SFP+ link core
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef SFPP_TB_TESTS_SVH
`define SFPP_TB_TESTS_SVH

// Single Wishbone transfer, checks the one-cycle acknowledge
task automatic bus_access(input logic we, input logic [7:0] adr,
                          input logic [31:0] wdat, output logic [31:0] rdat);
    int cyc;
    @(posedge wb_clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we <= we;
    wb_adr <= adr;
    wb_dat_w <= wdat;
    // Slave samples the request here
    @(posedge wb_clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we <= 1'b0;
    cyc = 0;
    do begin
        @(negedge wb_clk);
        cyc++;
    end while (wb_ack !== 1'b1 && cyc < ACK_LIMIT);
    rdat = wb_dat_r;
    if (wb_ack !== 1'b1) begin
        $display("no acknowledge for the access at address %h", adr);
        error_count++;
    end else begin
        check_value("wb_ack_o latency", cyc, 1);
    end
    // Exactly one acknowledge, then an idle data bus
    @(negedge wb_clk);
    check_value("wb_ack_o", wb_ack, 0);
    check_value("wb_dat_o", wb_dat_r, 0);
endtask

task automatic write_reg(input logic [7:0] adr, input logic [31:0] data);
    logic [31:0] rd;
    bus_access(1'b1, adr, data, rd);
    // No read word alongside a write acknowledge
    check_value("wb_dat_o", rd, 0);
endtask

task automatic read_reg(input logic [7:0] adr, output logic [31:0] data);
    bus_access(1'b0, adr, 32'h0, data);
endtask

function automatic logic reset_now(input int which);
    case (which)
        SIG_GT_RST: return gt_reset_all;
        SIG_TX_RST: return xgmii_tx_rst;
        default: return xgmii_rx_rst;
    endcase
endfunction

// Waits for a reset output to reach a level, counting its own clock
task automatic await_reset(input int which, input string name, input logic level,
                           input int limit, output int cycles);
    cycles = 0;
    do begin
        if (which == SIG_GT_RST) begin
            @(negedge freerun_clk);
        end else begin
            @(negedge xgmii_clk);
        end
        cycles++;
    end while (reset_now(which) !== level && cycles < limit);
    if (reset_now(which) !== level) begin
        $display("%s did not go to %0b within %0d cycles", name, level, limit);
        error_count++;
    end
endtask

// Random words on one source, expected at the PHY one cycle later
task automatic stream_and_compare(input logic use_rx, input int count);
    logic [63:0] data;
    logic [7:0]  ctrl;
    logic [63:0] prev_data;
    logic [7:0]  prev_ctrl;
    prev_data = '0;
    prev_ctrl = '0;
    for (int i = 0; i <= count; i++) begin
        data = random_bits(64);
        ctrl = 8'(random_bits(8));
        @(posedge xgmii_clk);
        if (use_rx) begin
            xgmii_rx_data <= data;
            xgmii_rx_ctrl <= ctrl;
        end else begin
            xgmii_tx_data <= data;
            xgmii_tx_ctrl <= ctrl;
        end
        @(negedge xgmii_clk);
        // First edge still registers the word from before the stream
        if (i > 0) begin
            check_value("xgmii_phy_tx_data_o", phy_tx_data, prev_data);
            check_value("xgmii_phy_tx_ctrl_o", phy_tx_ctrl, prev_ctrl);
        end
        prev_data = data;
        prev_ctrl = ctrl;
    end
endtask

task automatic reset_defaults_test();
    int          errors_at_start;
    int          cyc;
    logic [31:0] rd;
    errors_at_start = error_count;
    @(negedge freerun_clk);
    check_value("wb_ack_o", wb_ack, 0);
    check_value("wb_dat_o", wb_dat_r, 0);
    check_value("gt_control_o", gt_control, 0);
    check_value("gt_reset_all_o", gt_reset_all, 1);
    // Release count runs from the first edge with freerun reset low
    await_reset(SIG_GT_RST, "gt_reset_all_o", 1'b0, 4 * SYNC_STAGES, cyc);
    check_value("gt_reset_all_o release cycles", cyc, SYNC_STAGES);
    read_reg(REG_ID, rd);
    check_value("identity word", rd, 1);
    // Byte lane bits are ignored
    read_reg(8'h01, rd);
    check_value("identity word at 0x01", rd, 1);
    read_reg(8'h14, rd);
    check_value("undecoded word at 0x14", rd, 0);
    read_reg(8'hFC, rd);
    check_value("undecoded word at 0xFC", rd, 0);
    close_test("reset defaults", errors_at_start);
endtask

task automatic control_regs_test();
    int          errors_at_start;
    int          cyc;
    logic [31:0] wr;
    logic [31:0] rd;
    errors_at_start = error_count;
    for (int i = 0; i < 4; i++) begin
        wr = 32'(random_bits(32));
        write_reg(REG_GT_CONTROL, wr);
        read_reg(REG_GT_CONTROL, rd);
        check_value("gt control word", rd, wr & 32'h3F);
        // Bit 0 stays inside as the hold-reset request
        check_value("gt_control_o", gt_control, wr[5:0] & 6'h3E);
    end
    for (int i = 0; i < 4; i++) begin
        wr = 32'(random_bits(32));
        write_reg(REG_PHY_CONTROL, wr);
        read_reg(REG_PHY_CONTROL, rd);
        check_value("phy control word", rd, wr & 32'h1);
    end
    // Identity word is read only
    write_reg(REG_ID, 32'(random_bits(32)));
    read_reg(REG_ID, rd);
    check_value("identity word", rd, 1);
    write_reg(REG_GT_CONTROL, 32'h0);
    write_reg(REG_PHY_CONTROL, 32'h0);
    // A hold-reset left by the random words has to release
    await_reset(SIG_GT_RST, "gt_reset_all_o", 1'b0, 4 * SYNC_STAGES + 4, cyc);
    close_test("control registers", errors_at_start);
endtask

task automatic status_readback_test();
    int          errors_at_start;
    int          cyc;
    logic [12:0] gt;
    logic [1:0]  phy;
    logic [31:0] exp_word;
    logic [31:0] rd;
    errors_at_start = error_count;
    for (int i = 0; i < 4; i++) begin
        gt = 13'(random_bits(GT_STATUS_W));
        phy = 2'(random_bits(PHY_STATUS_W));
        // Last pattern also drops the PLL lock
        @(posedge wb_clk);
        gt_status <= gt;
        phy_status <= phy;
        pll_lock <= (i != 3);
        repeat (2 * SYNC_STAGES + 2) @(posedge wb_clk);
        exp_word = 32'(gt);
        exp_word[GT_STATUS_LOCK_RST] = (i == 3);
        exp_word[GT_STATUS_PLL_LOCK] = (i != 3);
        read_reg(REG_GT_STATUS, rd);
        check_value("gt status word", rd, exp_word);
        read_reg(8'h05, rd);
        check_value("gt status word at 0x05", rd, exp_word);
        read_reg(REG_PHY_STATUS, rd);
        check_value("phy status word", rd, 32'(phy));
    end
    @(posedge freerun_clk);
    pll_lock <= 1'b1;
    await_reset(SIG_GT_RST, "gt_reset_all_o", 1'b0, 2 * SYNC_STAGES + 2, cyc);
    close_test("status readback", errors_at_start);
endtask

task automatic gt_reset_test();
    int errors_at_start;
    int cyc;
    errors_at_start = error_count;
    // Driven on one edge, taken on the next, out right after it
    @(posedge freerun_clk);
    pll_lock <= 1'b0;
    await_reset(SIG_GT_RST, "gt_reset_all_o", 1'b1, 4, cyc);
    check_value("gt_reset_all_o assert cycles", cyc, 2);
    @(posedge freerun_clk);
    pll_lock <= 1'b1;
    await_reset(SIG_GT_RST, "gt_reset_all_o", 1'b0, 2 * SYNC_STAGES + 2, cyc);
    check_value("gt_reset_all_o release cycles", cyc, SYNC_STAGES + 1);
    // Hold-reset crosses into the freerun clock first
    write_reg(REG_GT_CONTROL, 32'h1);
    check_value("gt_control_o", gt_control, 0);
    await_reset(SIG_GT_RST, "gt_reset_all_o", 1'b1, SYNC_STAGES + 4, cyc);
    // Lock coming back alone keeps a held reset
    @(posedge freerun_clk);
    pll_lock <= 1'b0;
    repeat (2) @(posedge freerun_clk);
    pll_lock <= 1'b1;
    repeat (2 * SYNC_STAGES) @(negedge freerun_clk);
    check_value("gt_reset_all_o", gt_reset_all, 1);
    write_reg(REG_GT_CONTROL, 32'h0);
    await_reset(SIG_GT_RST, "gt_reset_all_o", 1'b0, 3 * SYNC_STAGES + 4, cyc);
    close_test("transceiver reset", errors_at_start);
endtask

task automatic xgmii_path_test();
    int errors_at_start;
    int cyc;
    errors_at_start = error_count;
    @(posedge xgmii_clk);
    gt_status[GT_STATUS_TX_DONE] <= 1'b0;
    gt_status[GT_STATUS_RX_DONE] <= 1'b0;
    await_reset(SIG_TX_RST, "xgmii_tx_rst_o", 1'b1, 4, cyc);
    await_reset(SIG_RX_RST, "xgmii_rx_rst_o", 1'b1, 4, cyc);
    // Bridge words are replaced by idle during transmit reset
    for (int i = 0; i < 4; i++) begin
        @(posedge xgmii_clk);
        xgmii_tx_data <= random_bits(64);
        xgmii_tx_ctrl <= 8'(random_bits(8));
        @(negedge xgmii_clk);
        check_value("xgmii_phy_tx_data_o", phy_tx_data, IDLE_DATA);
        check_value("xgmii_phy_tx_ctrl_o", phy_tx_ctrl, IDLE_CTRL);
    end
    @(posedge xgmii_clk);
    gt_status[GT_STATUS_TX_DONE] <= 1'b1;
    gt_status[GT_STATUS_RX_DONE] <= 1'b1;
    await_reset(SIG_TX_RST, "xgmii_tx_rst_o", 1'b0, 2 * SYNC_STAGES + 2, cyc);
    await_reset(SIG_RX_RST, "xgmii_rx_rst_o", 1'b0, 2, cyc);
    stream_and_compare(1'b0, 6);
    // Loopback select needs its crossing into the transmit clock
    write_reg(REG_PHY_CONTROL, 32'h1);
    repeat (2 * SYNC_STAGES) @(posedge xgmii_clk);
    stream_and_compare(1'b1, 6);
    write_reg(REG_PHY_CONTROL, 32'h0);
    close_test("xgmii path", errors_at_start);
endtask

`endif

//--- test/tb_sfpp_link_ctrl.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the SFP+ link control core
// Clocks, Wishbone master, transceiver model and checks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_sfpp_link_ctrl;

    timeunit 1ns;
    timeprecision 1ps;

    import sfpp_csr_pkg::*;
    import xgmii_pkg::*;

    localparam int SYNC_STAGES  = 4;
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 5;
    localparam int ACK_LIMIT    = 8;
    // Reset, then the five tests in order, then a margin
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 40 + 150 + 150 + 100 + 100 + 200;
    localparam logic [31:0] LFSR_SEED = 32'h20d960f1;
    // Idle on all eight lanes
    localparam logic [63:0] IDLE_DATA = {8{8'h07}};
    localparam logic [7:0]  IDLE_CTRL = 8'hFF;
    // Reset outputs that await_reset can follow
    localparam int SIG_GT_RST = 0;
    localparam int SIG_TX_RST = 1;
    localparam int SIG_RX_RST = 2;

    logic        wb_clk = 1'b0;
    logic        freerun_clk = 1'b0;
    // One source for both XGMII clocks, as on a locked link
    logic        xgmii_clk = 1'b0;
    logic        reset;
    logic        freerun_rst;
    logic        pll_lock;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [7:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic [12:0] gt_status;
    logic [1:0]  phy_status;
    logic        gt_reset_all;
    logic [5:0]  gt_control;
    logic [63:0] xgmii_tx_data;
    logic [7:0]  xgmii_tx_ctrl;
    logic [63:0] xgmii_rx_data;
    logic [7:0]  xgmii_rx_ctrl;
    logic [63:0] phy_tx_data;
    logic [7:0]  phy_tx_ctrl;
    logic        xgmii_tx_rst;
    logic        xgmii_rx_rst;

    int          error_count = 0;
    int          check_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    logic [31:0] lfsr_state = LFSR_SEED;

    always #(CLK_PERIOD / 2) wb_clk = ~wb_clk;
    always #(CLK_PERIOD / 2) freerun_clk = ~freerun_clk;
    always #(CLK_PERIOD / 2) xgmii_clk = ~xgmii_clk;

    sfpp_link_ctrl #(
        .SYNC_STAGES (SYNC_STAGES)
    ) i_dut (
        .wb_clk_i            (wb_clk),
        .reset_i             (reset),
        .freerun_clk_i       (freerun_clk),
        .freerun_rst_i       (freerun_rst),
        .xgmii_tx_clk_i      (xgmii_clk),
        .xgmii_rx_clk_i      (xgmii_clk),
        .pll_lock_i          (pll_lock),
        .wb_cyc_i            (wb_cyc),
        .wb_stb_i            (wb_stb),
        .wb_we_i             (wb_we),
        .wb_adr_i            (wb_adr),
        .wb_dat_i            (wb_dat_w),
        .wb_dat_o            (wb_dat_r),
        .wb_ack_o            (wb_ack),
        .gt_status_i         (gt_status),
        .phy_status_i        (phy_status),
        .gt_reset_all_o      (gt_reset_all),
        .gt_control_o        (gt_control),
        .xgmii_tx_data_i     (xgmii_tx_data),
        .xgmii_tx_ctrl_i     (xgmii_tx_ctrl),
        .xgmii_rx_data_i     (xgmii_rx_data),
        .xgmii_rx_ctrl_i     (xgmii_rx_ctrl),
        .xgmii_phy_tx_data_o (phy_tx_data),
        .xgmii_phy_tx_ctrl_o (phy_tx_ctrl),
        .xgmii_tx_rst_o      (xgmii_tx_rst),
        .xgmii_rx_rst_o      (xgmii_rx_rst)
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [63:0] random_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[62:0], lfsr_state[0]};
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: got %h, expected %h at %0t", name, actual, expected,
                     $time);
        end
    endtask

    task automatic close_test(input string name, input int errors_at_start);
        tests_run++;
        if (error_count != errors_at_start) begin
            tests_failed++;
            $display("test %s: failed, %0d errors", name, error_count - errors_at_start);
        end else begin
            $display("test %s: passed", name);
        end
    endtask

    `include "sfpp_tb_tests.svh"

    initial begin
        // Quiet bus, locked PLL and all reset-done flags up
        reset = 1'b1;
        freerun_rst = 1'b1;
        pll_lock = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        gt_status = '1;
        phy_status = '0;
        xgmii_tx_data = '0;
        xgmii_tx_ctrl = '0;
        xgmii_rx_data = '0;
        xgmii_rx_ctrl = '0;
        repeat (RESET_CYCLES) @(posedge wb_clk);
        reset <= 1'b0;
        freerun_rst <= 1'b0;
        reset_defaults_test();
        control_regs_test();
        status_readback_test();
        gt_reset_test();
        xgmii_path_test();
        $display("%0d tests run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Watchdog against a stalled sequence
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired, tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
hdl/sfpp_csr_pkg.sv
hdl/xgmii_pkg.sv
hdl/reset_sync.sv
hdl/level_sync.sv
hdl/xgmii_loopback.sv
hdl/sfpp_csr.sv
hdl/sfpp_link_ctrl.sv
test/tb_sfpp_link_ctrl.sv
